// File: logic/ntm_defines.svh
`ifndef NTM_DEFINES_SVH
`define NTM_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Element and modulus width
`define NTM_DATA_W 16

// Row and column sizes, row and column counters
`define NTM_IDX_W 8

//////////////////////////////////////////////////
// Stream credits
//////////////////////////////////////////////////

// Input buffer entries, also the source's starting credits
`define NTM_IN_DEPTH 4

// Result slots held by the sink
`define NTM_OUT_CREDITS 4

`endif

// File: logic/ntm_pkg.sv
`include "ntm_defines.svh"

package ntm_pkg;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Operation selected by the command
  typedef enum logic {
    NTM_OP_ADD = 1'b0,
    NTM_OP_SUB = 1'b1
  } ntm_op_e;

  // Row walk of the matrix controller
  typedef enum logic [1:0] {
    MAT_IDLE     = 2'd0,
    MAT_ROW      = 2'd1,
    MAT_WAIT_ROW = 2'd2
  } ntm_mat_state_e;

  //////////////////////////////////////////////////
  // Stream payloads
  //////////////////////////////////////////////////

  // One command, 33 bits
  typedef struct packed {
    ntm_op_e                 op;
    logic [`NTM_DATA_W-1:0] modulus;
    logic [`NTM_IDX_W-1:0]  size_i;
    logic [`NTM_IDX_W-1:0]  size_j;
  } ntm_cmd_t;

  // Operand pair, A in the upper half
  typedef struct packed {
    logic [`NTM_DATA_W-1:0] a;
    logic [`NTM_DATA_W-1:0] b;
  } ntm_pair_t;

  // Result with end-of-row and end-of-matrix tags
  typedef struct packed {
    logic [`NTM_DATA_W-1:0] data;
    logic                   last_j;
    logic                   last_i;
  } ntm_result_t;

endpackage

// File: logic/ntm_scalar_adder.sv
`include "ntm_defines.svh"

module ntm_scalar_adder (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   s_valid,
  input  ntm_pkg::ntm_pair_t     s_pair,
  input  ntm_pkg::ntm_op_e       op,
  input  logic [`NTM_DATA_W-1:0] modulus,
  input  logic                   s_last_j,
  input  logic                   s_last_i,
  output logic                   r_valid,
  output ntm_pkg::ntm_result_t   r_result
);

  //////////////////////////////////////////////////
  // Stage one, raw sum or difference
  //////////////////////////////////////////////////

  // Top bit is carry for add, borrow for subtract
  logic [`NTM_DATA_W:0] raw;

  logic                 st1_valid;
  logic [`NTM_DATA_W:0] st1_raw;
  logic                 st1_sub;
  logic [`NTM_DATA_W:0] st1_mod;
  logic                 st1_last_j;
  logic                 st1_last_i;

  always_comb begin
    if (op == ntm_pkg::NTM_OP_SUB) begin
      raw = {1'b0, s_pair.a} - {1'b0, s_pair.b};
    end else begin
      raw = {1'b0, s_pair.a} + {1'b0, s_pair.b};
    end
  end

  // Valid bit only is cleared on reset
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      st1_valid <= 1'b0;
    end else begin
      st1_valid <= s_valid;
    end
  end

  // Modulus rides along with the raw value
  always_ff @(posedge CLK) begin
    st1_raw    <= raw;
    st1_sub    <= (op == ntm_pkg::NTM_OP_SUB);
    st1_mod    <= {1'b0, modulus};
    st1_last_j <= s_last_j;
    st1_last_i <= s_last_i;
  end

  //////////////////////////////////////////////////
  // Stage two, fold back into [0, M)
  //////////////////////////////////////////////////

  logic [`NTM_DATA_W:0] fixed;

  always_comb begin
    if (st1_sub) begin
      // Borrow set means difference went negative
      fixed = st1_raw[`NTM_DATA_W] ? st1_raw + st1_mod : st1_raw;
    end else begin
      fixed = (st1_raw >= st1_mod) ? st1_raw - st1_mod : st1_raw;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= st1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    r_result.data   <= fixed[`NTM_DATA_W-1:0];
    r_result.last_j <= st1_last_j;
    r_result.last_i <= st1_last_i;
  end

  // Operands must arrive already reduced
  a_operands_reduced : assert property (@(posedge CLK) disable iff (RST)
    s_valid |-> (s_pair.a < modulus) && (s_pair.b < modulus));

endmodule

// File: logic/ntm_vector_adder.sv
`include "ntm_defines.svh"

module ntm_vector_adder (
  input  logic                   CLK,
  input  logic                   RST,
  input  logic                   in_valid,
  input  ntm_pkg::ntm_pair_t     in_pair,
  output logic                   in_credit,
  input  logic                   out_credit,
  output logic                   out_valid,
  output ntm_pkg::ntm_result_t   out_result,
  input  logic                   row_start,
  input  logic [`NTM_IDX_W-1:0]  row_len,
  input  logic                   row_last,
  input  ntm_pkg::ntm_op_e       op,
  input  logic [`NTM_DATA_W-1:0] modulus,
  output logic                   row_done
);

  localparam int PTR_W  = (`NTM_IN_DEPTH > 1) ? $clog2(`NTM_IN_DEPTH) : 1;
  localparam int CNT_W  = $clog2(`NTM_IN_DEPTH + 1);
  localparam int CRED_W = $clog2(`NTM_OUT_CREDITS + 1);

  //////////////////////////////////////////////////
  // Input pair buffer
  //////////////////////////////////////////////////

  ntm_pkg::ntm_pair_t fifo_mem [`NTM_IN_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   fifo_cnt;

  logic [CRED_W-1:0]  out_cred;
  logic               row_active;
  logic [`NTM_IDX_W-1:0] col_idx;

  logic pop;
  logic last_j;

  // Pop needs an active row, a stored pair and a free result slot
  assign pop    = row_active && (fifo_cnt != '0) && (out_cred != '0);
  assign last_j = (col_idx == row_len - 1'b1);

  // Credit goes back as the pair leaves the buffer
  assign in_credit = pop;

  // Storage has no reset
  always_ff @(posedge CLK) begin
    if (in_valid) begin
      fifo_mem[wr_ptr] <= in_pair;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(`NTM_IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`NTM_IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fifo_cnt <= fifo_cnt + CNT_W'(in_valid) - CNT_W'(pop);
    end
  end

  //////////////////////////////////////////////////
  // Output credits and column walk
  //////////////////////////////////////////////////

  // Slot reserved at issue, freed by the sink
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_cred <= CRED_W'(`NTM_OUT_CREDITS);
    end else begin
      case ({pop, out_credit})
        2'b10:   out_cred <= out_cred - 1'b1;
        2'b01:   out_cred <= out_cred + 1'b1;
        default: out_cred <= out_cred;
      endcase
    end
  end

  // Row closes once its last column is issued
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_active <= 1'b0;
      col_idx    <= '0;
    end else if (row_start) begin
      row_active <= 1'b1;
      col_idx    <= '0;
    end else if (pop) begin
      if (last_j) begin
        row_active <= 1'b0;
        col_idx    <= '0;
      end else begin
        col_idx <= col_idx + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Arithmetic
  //////////////////////////////////////////////////

  ntm_pkg::ntm_result_t r_result;
  logic                 r_valid;

  ntm_scalar_adder scalar_adder0 (
    .CLK      (CLK),
    .RST      (RST),
    .s_valid  (pop),
    .s_pair   (fifo_mem[rd_ptr]),
    .op       (op),
    .modulus  (modulus),
    .s_last_j (last_j),
    .s_last_i (last_j && row_last),
    .r_valid  (r_valid),
    .r_result (r_result)
  );

  assign out_valid  = r_valid;
  assign out_result = r_result;

  // End of row seen at the output side
  assign row_done = r_valid && r_result.last_j;

  // Source honours its credits
  a_no_push_full : assert property (@(posedge CLK) disable iff (RST)
    in_valid |-> (fifo_cnt < CNT_W'(`NTM_IN_DEPTH)));

  // Sink never returns more than it was given
  a_cred_bound : assert property (@(posedge CLK) disable iff (RST)
    out_cred <= CRED_W'(`NTM_OUT_CREDITS));

endmodule

// File: logic/ntm_matrix_adder.sv
`include "ntm_defines.svh"

module ntm_matrix_adder (
  input  logic                 CLK,
  input  logic                 RST,

  // Command port
  input  logic                 cmd_valid,
  input  ntm_pkg::ntm_cmd_t    cmd,
  output logic                 busy,

  // Element pairs in
  input  logic                 in_valid,
  input  ntm_pkg::ntm_pair_t   in_pair,
  output logic                 in_credit,

  // Results out
  output logic                 out_valid,
  output ntm_pkg::ntm_result_t out_result,
  input  logic                 out_credit
);

  //////////////////////////////////////////////////
  // Command register and row state
  //////////////////////////////////////////////////

  ntm_pkg::ntm_mat_state_e state_q;
  ntm_pkg::ntm_cmd_t       cmd_q;
  logic [`NTM_IDX_W-1:0]   row_cnt;

  logic cmd_accept;
  logic row_start;
  logic row_last;
  logic row_done;

  // Busy whenever a command is in flight
  assign busy       = (state_q != ntm_pkg::MAT_IDLE);
  assign cmd_accept = cmd_valid && !busy;

  // Single-cycle row kick
  assign row_start = (state_q == ntm_pkg::MAT_ROW);

  // Final row of the matrix
  assign row_last = (row_cnt == cmd_q.size_i - 1'b1);

  // Held for the whole command
  always_ff @(posedge CLK) begin
    if (cmd_accept) begin
      cmd_q <= cmd;
    end
  end

  //////////////////////////////////////////////////
  // Row FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state_q <= ntm_pkg::MAT_IDLE;
      row_cnt <= '0;
    end else begin
      case (state_q)
        ntm_pkg::MAT_IDLE: begin
          // Wait for a command
          if (cmd_accept) begin
            row_cnt <= '0;
            state_q <= ntm_pkg::MAT_ROW;
          end
        end

        ntm_pkg::MAT_ROW: begin
          // Row started this cycle
          state_q <= ntm_pkg::MAT_WAIT_ROW;
        end

        ntm_pkg::MAT_WAIT_ROW: begin
          if (row_done) begin
            if (row_last) begin
              // Last result out, drop busy next cycle
              state_q <= ntm_pkg::MAT_IDLE;
            end else begin
              row_cnt <= row_cnt + 1'b1;
              state_q <= ntm_pkg::MAT_ROW;
            end
          end
        end

        default: begin
          state_q <= ntm_pkg::MAT_IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Row engine
  //////////////////////////////////////////////////

  // Columns per row come from size_j
  ntm_vector_adder vector_adder0 (
    .CLK        (CLK),
    .RST        (RST),
    .in_valid   (in_valid),
    .in_pair    (in_pair),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .row_start  (row_start),
    .row_len    (cmd_q.size_j),
    .row_last   (row_last),
    .op         (cmd_q.op),
    .modulus    (cmd_q.modulus),
    .row_done   (row_done)
  );

  // A row can only finish inside a command
  a_no_done_idle : assert property (@(posedge CLK) disable iff (RST)
    !(row_done && (state_q == ntm_pkg::MAT_IDLE)));

endmodule

// File: bench/ntm_bench_util.svh
`ifndef NTM_BENCH_UTIL_SVH
`define NTM_BENCH_UTIL_SVH

//////////////////////////////////////////////////
// Random source
//////////////////////////////////////////////////

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h516427a5;

function automatic logic lfsr_step();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

// One step per bit taken
function automatic int rand_bits(input int n);
  int v;
  v = 0;
  for (int k = 0; k < n; k++) begin
    v = (v << 1) | int'(lfsr_step());
  end
  return v;
endfunction

//////////////////////////////////////////////////
// Error bookkeeping
//////////////////////////////////////////////////

int value_errors = 0;
int proto_errors = 0;

task automatic check_value(input string what, input int got, input int want);
  if (got != want) begin
    value_errors++;
    $display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, got, want);
  end
endtask

`endif

// File: bench/ntm_matrix_adder_tb.sv
`include "ntm_defines.svh"

module ntm_matrix_adder_tb;

  `include "ntm_bench_util.svh"

  localparam int WAIT_LIMIT = 400;

  logic                 CLK;
  logic                 RST;
  logic                 cmd_valid;
  ntm_pkg::ntm_cmd_t    cmd;
  logic                 busy;
  logic                 in_valid;
  ntm_pkg::ntm_pair_t   in_pair;
  logic                 in_credit;
  logic                 out_valid;
  ntm_pkg::ntm_result_t out_result;
  logic                 out_credit;

  // Case file contents, elements grouped per command
  ntm_pkg::ntm_cmd_t      cmds[$];
  int                     el_count[$];
  logic [`NTM_DATA_W-1:0] el_a[$];
  logic [`NTM_DATA_W-1:0] el_b[$];
  logic [`NTM_DATA_W-1:0] el_exp[$];

  // Scoreboard and credit bookkeeping
  ntm_pkg::ntm_result_t expected[$];
  ntm_pkg::ntm_result_t want;
  int   sink_due[$];
  int   cycle        = 0;
  int   src_credits  = `NTM_IN_DEPTH;
  int   sent         = 0;
  int   credits_back = 0;
  int   uncredited   = 0;
  int   hold_until   = 0;
  logic prev_last_i  = 1'b0;
  logic stopped      = 1'b0;

  ntm_matrix_adder dut0 (
    .CLK        (CLK),
    .RST        (RST),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .busy       (busy),
    .in_valid   (in_valid),
    .in_pair    (in_pair),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_credit (out_credit)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle++;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Modular rule, operands already below m
  function automatic int mod_result(input ntm_pkg::ntm_op_e op, input int m,
                                    input int a, input int b);
    if (op == ntm_pkg::NTM_OP_SUB) begin
      return (a - b + m) % m;
    end
    return (a + b) % m;
  endfunction

  // Early end of the command walk
  task automatic stop_run(input string why);
    $display("Run stopped: %s at time %0t", why, $time);
    stopped = 1'b1;
  endtask

  // Sampled on falling edges
  task automatic wait_busy(input logic level);
    int n;
    n = 0;
    @(negedge CLK);
    while (busy !== level && n <= WAIT_LIMIT) begin
      n++;
      @(negedge CLK);
    end
    if (n > WAIT_LIMIT) stop_run("busy never reached the expected level");
  endtask

  // Entered and left just after a rising edge
  task automatic send_pair(input logic [`NTM_DATA_W-1:0] a, input logic [`NTM_DATA_W-1:0] b);
    int n;
    n = 0;
    while (src_credits == 0 && n <= WAIT_LIMIT) begin
      @(posedge CLK);
      #1;
      n++;
    end
    if (n > WAIT_LIMIT) begin
      stop_run("source never got an input credit back");
    end else begin
      in_valid  = 1'b1;
      in_pair.a = a;
      in_pair.b = b;
      src_credits--;
      sent++;
      @(posedge CLK);
      #1;
      in_valid = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Output monitor and sink
  //////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (in_credit) begin
        src_credits++;
        credits_back++;
      end
      check_value("input credits within elements sent", credits_back <= sent, 1);
      // busy drops the cycle after the final result
      if (prev_last_i) check_value("busy after final result", busy, 0);
      prev_last_i = 1'b0;
      if (out_valid) begin
        check_value("busy while results leave", busy, 1);
        if (expected.size() == 0) begin
          proto_errors++;
          $display("Result %0h at time %0t arrived with none expected", out_result.data, $time);
        end else begin
          want = expected.pop_front();
          check_value("result data", out_result.data, want.data);
          check_value("result last_j", out_result.last_j, want.last_j);
          check_value("result last_i", out_result.last_i, want.last_i);
        end
        prev_last_i = out_result.last_i;
        uncredited++;
        sink_due.push_back(cycle + rand_bits(3));
      end
      check_value("results awaiting sink credit", uncredited <= `NTM_OUT_CREDITS, 1);
    end
  end

  // One credit per cycle, none during a hold
  always @(posedge CLK) begin
    #1;
    out_credit = 1'b0;
    if (!RST && cycle >= hold_until && sink_due.size() != 0) begin
      if (sink_due[0] <= cycle) begin
        out_credit = 1'b1;
        void'(sink_due.pop_front());
        uncredited--;
      end
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    int fd;
    int code;
    int op;
    int m;
    int si;
    int sj;
    int ea;
    int eb;
    int ee;
    int base;
    int n;
    logic [7:0]       tag;
    logic [8*128-1:0] line;
    ntm_pkg::ntm_cmd_t    c_rd;
    ntm_pkg::ntm_result_t r;

    RST        = 1'b1;
    cmd_valid  = 1'b0;
    cmd        = '0;
    in_valid   = 1'b0;
    in_pair    = '0;
    out_credit = 1'b0;

    // C lines open a command, E lines belong to it
    fd = $fopen("bench/ntm_matrix_cases.txt", "r");
    if (fd == 0) begin
      stop_run("case file could not be opened");
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag == "C") begin
          code = $fscanf(fd, "%d %h %d %d", op, m, si, sj);
          if (code != 4) stop_run("malformed command line in case file");
          c_rd.op      = ntm_pkg::ntm_op_e'(op);
          c_rd.modulus = m[`NTM_DATA_W-1:0];
          c_rd.size_i  = si[`NTM_IDX_W-1:0];
          c_rd.size_j  = sj[`NTM_IDX_W-1:0];
          cmds.push_back(c_rd);
          el_count.push_back(0);
        end else if (tag == "E") begin
          code = $fscanf(fd, "%h %h %h", ea, eb, ee);
          if (code != 3) stop_run("malformed element line in case file");
          el_a.push_back(ea[`NTM_DATA_W-1:0]);
          el_b.push_back(eb[`NTM_DATA_W-1:0]);
          el_exp.push_back(ee[`NTM_DATA_W-1:0]);
          el_count[el_count.size()-1]++;
        end else begin
          void'($fgets(line, fd));
        end
      end
      $fclose(fd);
    end

    repeat (5) @(posedge CLK);
    #1;
    RST = 1'b0;
    @(negedge CLK);
    check_value("busy after reset", busy, 0);
    check_value("out_valid after reset", out_valid, 0);
    check_value("in_credit after reset", in_credit, 0);

    base = 0;
    for (int c = 0; c < cmds.size() && !stopped; c++) begin
      check_value("elements listed for command", el_count[c],
                  cmds[c].size_i * cmds[c].size_j);
      @(posedge CLK);
      #1;
      cmd_valid = 1'b1;
      cmd       = cmds[c];
      wait_busy(1'b1);
      // Sink sits on its credits for part of the commands
      if (c % 3 == 1) hold_until = cycle + 30;
      @(posedge CLK);
      #1;
      cmd_valid = 1'b0;
      for (int k = 0; k < el_count[c] && !stopped; k++) begin
        r.data   = `NTM_DATA_W'(mod_result(cmds[c].op, cmds[c].modulus,
                                           el_a[base+k], el_b[base+k]));
        r.last_j = ((k + 1) % cmds[c].size_j == 0);
        r.last_i = (k == el_count[c] - 1);
        check_value("case file expected value", el_exp[base+k], r.data);
        expected.push_back(r);
        repeat (rand_bits(2)) begin
          @(posedge CLK);
          #1;
        end
        send_pair(el_a[base+k], el_b[base+k]);
      end
      base += el_count[c];
      if (!stopped) wait_busy(1'b0);
    end

    // Drain results and sink credits
    n = 0;
    while ((expected.size() != 0 || uncredited != 0) && n <= WAIT_LIMIT && !stopped) begin
      @(negedge CLK);
      n++;
    end
    if (n > WAIT_LIMIT) stop_run("results or sink credits still outstanding");
    if (!stopped) check_value("input credits back at source", src_credits, `NTM_IN_DEPTH);

    $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
    if (!stopped && value_errors + proto_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+logic
+incdir+bench
logic/ntm_pkg.sv
logic/ntm_scalar_adder.sv
logic/ntm_vector_adder.sv
logic/ntm_matrix_adder.sv
bench/ntm_matrix_adder_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ntm_matrix_adder_tb
FILELIST  = verilog.f

.PHONY: sim clean

# Build, run, then look for the pass message in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: bench/ntm_matrix_cases.txt
# C op(0 add, 1 sub) modulus_hex size_i size_j
# E a_hex b_hex expected_hex, row-major under the preceding C
C 0 0007 1 1
E 0003 0005 0001
C 1 000d 1 5
E 0002 0009 0006
E 0009 0009 0000
E 000c 0003 0009
E 0000 000c 0001
E 0005 0000 0005
# modulus of one, every result is zero
C 0 0001 3 1
E 0000 0000 0000
E 0000 0000 0000
E 0000 0000 0000
C 0 fff1 3 4
E fff0 0001 0000
E fff0 fff0 ffef
E 1234 4321 5555
E 8000 8000 000f
E 0000 0000 0000
E abcd 1111 bcde
E 7fff 7ff2 0000
E fff0 0002 0001
E 0001 0001 0002
E 9000 7000 000f
E 00ff ff00 000e
E ffee 0002 fff0
C 1 fff1 3 4
E 0000 0001 fff0
E 1234 1234 0000
E 5555 1234 4321
E 0001 fff0 0002
E fff0 0000 fff0
E 8000 8001 fff0
E 0010 0020 ffe1
E abcd abcc 0001
E 7000 9000 dff1
E ffef fff0 fff0
E 0100 00ff 0001
E 0000 ffee 0003
C 0 0064 1 3
E 0032 0032 0000
E 0063 0063 0062
E 000a 0014 001e
C 1 0002 3 1
E 0001 0000 0001
E 0000 0001 0001
E 0001 0001 0000
